/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_cpu_top
FILELIST   := all.f
OBJ_DIR    := obj_dir
COMMON     := --timing --assert --timescale 1ns/1ps
SIM_FLAGS  := --binary $(COMMON)
LINT_FLAGS := --lint-only $(COMMON)
PASS_MSG   := All tests passed!

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* all.f */
verilog/cpu_pkg.sv
verilog/fetch_push_if.sv
verilog/issue_if.sv
verilog/fetch_unit.sv
verilog/inst_fifo.sv
verilog/inst_decoder.sv
verilog/regfile.sv
verilog/issue_exec.sv
verilog/cpu_top.sv
tests/cpu_asserts.sv
tests/tb_cpu_top.sv

/* tests/cpu_asserts.sv */
module cpu_asserts import cpu_pkg::*; (
    input logic     clk,
    input logic     rst_i,
    input logic     stb_i,
    input logic     ack_i,
    input addr_t    adr_i,
    input logic     pop1_i,
    input logic     m_wen_i,
    input reg_idx_t m_wnum_i,
    input reg_idx_t s_rs_i,
    input reg_idx_t s_rt_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // a pending request keeps stb and address until ack
    assert property (@(posedge clk) disable iff (rst_i)
        stb_i && !ack_i |=> stb_i && $stable(adr_i))
        else $error("instruction request changed before its ack");

    // slave never reads the master destination
    assert property (@(posedge clk) disable iff (rst_i)
        pop1_i && m_wen_i |-> (s_rs_i != m_wnum_i) && (s_rt_i != m_wnum_i))
        else $error("slave issued while reading the master destination");

endmodule

bind fetch_unit cpu_asserts u_bus_asserts (
    .clk      (clk),
    .rst_i    (rst_i),
    .stb_i    (imem_stb_o),
    .ack_i    (imem_ack_i),
    .adr_i    (imem_adr_o),
    .pop1_i   (1'b0),
    .m_wen_i  (1'b0),
    .m_wnum_i ('0),
    .s_rs_i   ('0),
    .s_rt_i   ('0)
);

bind issue_exec cpu_asserts u_issue_asserts (
    .clk      (clk),
    .rst_i    (rst_i),
    .stb_i    (1'b0),
    .ack_i    (1'b0),
    .adr_i    ('0),
    .pop1_i   (issue_i.pop1),
    .m_wen_i  (m_wen),
    .m_wnum_i (m_wnum),
    .s_rs_i   (s_rs),
    .s_rt_i   (s_rt)
);

/* tests/cpu_tests.txt */
// each line holds an instruction word then its expected destination then its expected value
// the first word counts the program lines and destination 00 marks an instruction without write
18
24010005 01 00000005
2402fffd 02 fffffffd
3c031234 03 12340000
34048765 04 00008765
00222821 05 00000002
00a13023 06 fffffffd
00643825 07 12348765
00e44024 08 00008765
01024826 09 ffff7898
0041502a 0a 00000001
0022582a 0b 00000000
00016100 0c 00000050
304dff0f 0d 0000ff0d
388effff 0e 0000789a
24200007 00 00000000
00017821 0f 00000005
fc221234 00 00000000
00408025 10 fffffffd
2421fff0 01 fffffff5
24210020 01 00000015
3c12ffff 12 ffff0000
00129a00 13 ff000000
0272a023 14 ff010000
00210026 00 00000000

/* tests/tb_cpu_top.sv */
module tb_cpu_top import cpu_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD      = 10;
    localparam int RESET_CYCLES    = 16;
    localparam int MAX_TESTS       = 64;
    localparam int CYCLES_PER_TEST = 40;
    localparam int MAX_DELAY       = 5;

    logic           clk        = 1'b0;
    logic           rst_i      = 1'b1;
    logic           imem_cyc_o;
    logic           imem_stb_o;
    addr_t          imem_adr_o;
    inst_pair_t     imem_dat_i = '0;
    logic           imem_ack_i = 1'b0;
    logic [1:0]     retire_valid_o;
    addr_t [1:0]    retire_pc_o;
    logic [1:0]     retire_wen_o;
    reg_idx_t [1:0] retire_wnum_o;
    word_t [1:0]    retire_wdata_o;

    // count word first, then three words per program line
    logic [31:0] tv_raw [1 + 3 * MAX_TESTS];
    int          n_tests           = 0;
    logic        tv_loaded         = 1'b0;
    int          n_retired         = 0;
    logic        dual_seen         = 1'b0;
    logic        first_req_done    = 1'b0;
    int          post_reset_cycles = 0;
    int unsigned lcg_state         = 32'd11;
    int unsigned wait_left         = 0;
    logic        req_busy          = 1'b0;
    int          mem_idx;

    always #(CLK_PERIOD / 2) clk = ~clk;

    cpu_top DUT (
        .clk            (clk),
        .rst_i          (rst_i),
        .imem_cyc_o     (imem_cyc_o),
        .imem_stb_o     (imem_stb_o),
        .imem_adr_o     (imem_adr_o),
        .imem_dat_i     (imem_dat_i),
        .imem_ack_i     (imem_ack_i),
        .retire_valid_o (retire_valid_o),
        .retire_pc_o    (retire_pc_o),
        .retire_wen_o   (retire_wen_o),
        .retire_wnum_o  (retire_wnum_o),
        .retire_wdata_o (retire_wdata_o)
    );

    function automatic int unsigned lcg_next(int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // zero words past the end of the program
    function automatic inst_t prog_word(int idx);
        if (idx >= 0 && idx < n_tests) begin
            return tv_raw[1 + 3 * idx];
        end else begin
            return '0;
        end
    endfunction

    function automatic reg_idx_t dest_of(int idx);
        if (idx >= 0 && idx < n_tests) begin
            return tv_raw[2 + 3 * idx][4:0];
        end else begin
            return '0;
        end
    endfunction

    function automatic word_t value_of(int idx);
        return tv_raw[3 + 3 * idx];
    endfunction

    function automatic logic reads_reg(inst_t inst, reg_idx_t r);
        logic [5:0] op;
        logic       hit;
        op  = inst[31:26];
        hit = 1'b0;
        if (op == OP_SPECIAL) begin
            hit = (inst[20:16] == r) || ((inst[5:0] != FN_SLL) && (inst[25:21] == r));
        end else if (op == OP_ADDIU || op == OP_ANDI || op == OP_ORI || op == OP_XORI) begin
            hit = (inst[25:21] == r);
        end
        return hit;
    endfunction

    task automatic stop_with_failure(string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("error: %s is %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_retirement(int lane);
        int idx;
        idx = n_retired;
        check_value($sformatf("retire_pc_o[%0d]", lane), retire_pc_o[lane],
                    RESET_PC + 32'(4 * idx));
        if (dest_of(idx) == '0) begin
            check_value($sformatf("retire_wen_o[%0d]", lane), 32'(retire_wen_o[lane]), 32'd0);
        end else begin
            check_value($sformatf("retire_wen_o[%0d]", lane), 32'(retire_wen_o[lane]), 32'd1);
            check_value($sformatf("retire_wnum_o[%0d]", lane), 32'(retire_wnum_o[lane]),
                        32'(dest_of(idx)));
            check_value($sformatf("retire_wdata_o[%0d]", lane), retire_wdata_o[lane],
                        value_of(idx));
        end
        n_retired = n_retired + 1;
    endtask

    task automatic check_dual_pair();
        reg_idx_t dest0;
        dest0 = dest_of(n_retired - 2);
        if (dest0 != '0 && reads_reg(prog_word(n_retired - 1), dest0)) begin
            stop_with_failure("lane 1 read the register that lane 0 wrote in the same cycle");
        end else if (n_retired - 1 < n_tests) begin
            dual_seen = 1'b1;
        end
    endtask

    // wishbone slave with a random ack delay
    always @(posedge clk) begin
        if (rst_i) begin
            imem_ack_i <= 1'b0;
            req_busy = 1'b0;
        end else if (imem_ack_i) begin
            imem_ack_i <= 1'b0;
        end else if (imem_cyc_o && imem_stb_o) begin
            if (!req_busy) begin
                lcg_state = lcg_next(lcg_state);
                wait_left = (lcg_state >> 16) % 32'(MAX_DELAY + 1);
                req_busy  = 1'b1;
            end
            if (wait_left == 0) begin
                mem_idx = int'((imem_adr_o - RESET_PC) >> 2);
                imem_dat_i <= {prog_word(mem_idx + 1), prog_word(mem_idx)};
                imem_ack_i <= 1'b1;
                req_busy = 1'b0;
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

    always @(negedge clk) begin
        if (rst_i || post_reset_cycles == 0) begin
            check_value("imem_cyc_o", 32'(imem_cyc_o), 32'd0);
            check_value("imem_stb_o", 32'(imem_stb_o), 32'd0);
            check_value("retire_valid_o", 32'(retire_valid_o), 32'd0);
        end
        if (!rst_i) begin
            post_reset_cycles = post_reset_cycles + 1;
            if (imem_stb_o && !first_req_done) begin
                check_value("imem_adr_o", imem_adr_o, RESET_PC);
                first_req_done = 1'b1;
            end
            // program order is lane 0 before lane 1
            if (retire_valid_o[0]) begin
                check_retirement(0);
            end
            if (retire_valid_o[1]) begin
                check_retirement(1);
            end
            if (retire_valid_o == 2'b11) begin
                check_dual_pair();
            end
        end
    end

    initial begin
        $readmemh("tests/cpu_tests.txt", tv_raw);
        n_tests = int'(tv_raw[0]);
        if (n_tests < 1 || n_tests > MAX_TESTS) begin
            stop_with_failure("the test file does not hold a valid program length");
        end else begin
            tv_loaded = 1'b1;
            repeat (RESET_CYCLES) @(posedge clk);
            rst_i <= 1'b0;
            wait (n_retired >= n_tests);
            @(posedge clk);
            // the opening pair is independent
            if (dual_seen) begin
                $display("All tests passed!");
                $finish;
            end else begin
                stop_with_failure("no cycle retired program instructions on both lanes");
            end
        end
    end

    initial begin
        wait (tv_loaded);
        #(CLK_PERIOD * CYCLES_PER_TEST * n_tests);
        stop_with_failure("timeout, the program did not finish retiring in time");
    end

endmodule

/* verilog/cpu_pkg.sv */
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;
    // low half holds the instruction at the lower address
    typedef logic [63:0] inst_pair_t;
    typedef logic [4:0]  reg_idx_t;

    localparam addr_t RESET_PC   = 32'hbfc0_0000;
    localparam int    FIFO_DEPTH = 8;

    typedef logic [$clog2(FIFO_DEPTH):0] fifo_cnt_t;

    typedef enum logic [3:0] {
        ALU_NONE,
        ALU_ADDU,
        ALU_SUBU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_LUI
    } alu_op_e;

    typedef enum logic {
        FETCH_IDLE,
        FETCH_WAIT
    } fetch_state_e;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    // function field of SPECIAL
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

endpackage

/* verilog/cpu_top.sv */
module cpu_top import cpu_pkg::*; (
    input  logic              clk,
    input  logic              rst_i,

    output logic              imem_cyc_o,
    output logic              imem_stb_o,
    output addr_t             imem_adr_o,
    input  inst_pair_t        imem_dat_i,
    input  logic              imem_ack_i,

    output logic [1:0]        retire_valid_o,
    output addr_t [1:0]       retire_pc_o,
    output logic [1:0]        retire_wen_o,
    output reg_idx_t [1:0]    retire_wnum_o,
    output word_t [1:0]       retire_wdata_o
);

    fetch_push_if push_bus ();
    issue_if      issue_bus ();

    fetch_unit u_fetch_unit (
        .clk        (clk),
        .rst_i      (rst_i),
        .imem_cyc_o (imem_cyc_o),
        .imem_stb_o (imem_stb_o),
        .imem_adr_o (imem_adr_o),
        .imem_dat_i (imem_dat_i),
        .imem_ack_i (imem_ack_i),
        .push_o     (push_bus.producer)
    );

    inst_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_inst_fifo (
        .clk     (clk),
        .rst_i   (rst_i),
        .push_i  (push_bus.consumer),
        .issue_o (issue_bus.producer)
    );

    issue_exec u_issue_exec (
        .clk            (clk),
        .rst_i          (rst_i),
        .issue_i        (issue_bus.consumer),
        .retire_valid_o (retire_valid_o),
        .retire_pc_o    (retire_pc_o),
        .retire_wen_o   (retire_wen_o),
        .retire_wnum_o  (retire_wnum_o),
        .retire_wdata_o (retire_wdata_o)
    );

endmodule

/* verilog/fetch_push_if.sv */
interface fetch_push_if import cpu_pkg::*; ();

    logic       push;
    addr_t      pc;
    inst_pair_t pair;
    // at least two free slots
    logic       room;

    modport producer (
        output push,
        output pc,
        output pair,
        input  room
    );

    modport consumer (
        input  push,
        input  pc,
        input  pair,
        output room
    );

endinterface

/* verilog/fetch_unit.sv */
module fetch_unit import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_i,

    output logic                  imem_cyc_o,
    output logic                  imem_stb_o,
    output addr_t                 imem_adr_o,
    input  inst_pair_t            imem_dat_i,
    input  logic                  imem_ack_i,

    fetch_push_if.producer        push_o
);

    fetch_state_e state;
    addr_t        pc;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state <= FETCH_IDLE;
            pc    <= RESET_PC;
        end else begin
            case (state)
                FETCH_IDLE: begin
                    // only start when the whole pair fits
                    if (push_o.room) begin
                        state <= FETCH_WAIT;
                    end
                end
                FETCH_WAIT: begin
                    if (imem_ack_i) begin
                        state <= FETCH_IDLE;
                        pc    <= pc + 32'd8;
                    end
                end
                default: begin
                    state <= FETCH_IDLE;
                end
            endcase
        end
    end

    // cyc and stb drop the cycle after ack
    assign imem_cyc_o = (state == FETCH_WAIT);
    assign imem_stb_o = (state == FETCH_WAIT);
    assign imem_adr_o = pc;

    // data sampled by the FIFO in the ack cycle
    assign push_o.push = (state == FETCH_WAIT) && imem_ack_i;
    assign push_o.pc   = pc;
    assign push_o.pair = imem_dat_i;

endmodule

/* verilog/inst_decoder.sv */
module inst_decoder import cpu_pkg::*; (
    input  inst_t       inst_i,
    output reg_idx_t    rs_o,
    output reg_idx_t    rt_o,
    output reg_idx_t    wnum_o,
    output word_t       imm_o,
    output logic [4:0]  shamt_o,
    output alu_op_e     alu_op_o,
    output logic        use_imm_o,
    output logic        wen_o
);

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [15:0] imm16;
    reg_idx_t    rd;

    assign opcode  = inst_i[31:26];
    assign rs_o    = inst_i[25:21];
    assign rt_o    = inst_i[20:16];
    assign rd      = inst_i[15:11];
    assign shamt_o = inst_i[10:6];
    assign funct   = inst_i[5:0];
    assign imm16   = inst_i[15:0];

    always_comb begin
        // I-type defaults, logical ops zero-extend
        alu_op_o  = ALU_NONE;
        use_imm_o = 1'b1;
        imm_o     = {16'b0, imm16};
        wnum_o    = rt_o;
        case (opcode)
            OP_SPECIAL: begin
                use_imm_o = 1'b0;
                wnum_o    = rd;
                case (funct)
                    FN_SLL:  alu_op_o = ALU_SLL;
                    FN_ADDU: alu_op_o = ALU_ADDU;
                    FN_SUBU: alu_op_o = ALU_SUBU;
                    FN_AND:  alu_op_o = ALU_AND;
                    FN_OR:   alu_op_o = ALU_OR;
                    FN_XOR:  alu_op_o = ALU_XOR;
                    FN_SLT:  alu_op_o = ALU_SLT;
                    default: alu_op_o = ALU_NONE;
                endcase
            end
            OP_ADDIU: begin
                alu_op_o = ALU_ADDU;
                imm_o    = {{16{imm16[15]}}, imm16};
            end
            OP_ANDI: alu_op_o = ALU_AND;
            OP_ORI:  alu_op_o = ALU_OR;
            OP_XORI: alu_op_o = ALU_XOR;
            OP_LUI: begin
                alu_op_o = ALU_LUI;
                imm_o    = {imm16, 16'b0};
            end
            default: alu_op_o = ALU_NONE;
        endcase
    end

    // unknown ops and r0 targets retire without a write
    assign wen_o = (alu_op_o != ALU_NONE) && (wnum_o != '0);

endmodule

/* verilog/inst_fifo.sv */
module inst_fifo import cpu_pkg::*; #(
    parameter int FIFO_DEPTH = cpu_pkg::FIFO_DEPTH
) (
    input  logic              clk,
    input  logic              rst_i,

    fetch_push_if.consumer    push_i,
    issue_if.producer         issue_o
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    inst_t inst_mem [FIFO_DEPTH];
    addr_t pc_mem   [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] wr_ptr_nx;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] rd_ptr_nx;
    logic [PTR_W:0]   count;
    logic [PTR_W:0]   n_push;
    logic [PTR_W:0]   n_pop;

    assign wr_ptr_nx = wr_ptr + 1'b1;
    assign rd_ptr_nx = rd_ptr + 1'b1;

    assign n_push = push_i.push ? (PTR_W+1)'(2) : '0;
    assign n_pop  = (PTR_W+1)'(issue_o.pop0) + (PTR_W+1)'(issue_o.pop1);

    // a push always fills two slots
    always_ff @(posedge clk) begin
        if (push_i.push) begin
            inst_mem[wr_ptr]    <= push_i.pair[31:0];
            pc_mem[wr_ptr]      <= push_i.pc;
            inst_mem[wr_ptr_nx] <= push_i.pair[63:32];
            pc_mem[wr_ptr_nx]   <= push_i.pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i.push) begin
                wr_ptr <= wr_ptr + PTR_W'(2);
            end
            rd_ptr <= rd_ptr + n_pop[PTR_W-1:0];
            count  <= count + n_push - n_pop;
        end
    end

    assign push_i.room = (count <= (PTR_W+1)'(FIFO_DEPTH - 2));

    assign issue_o.valid0 = (count != '0);
    assign issue_o.valid1 = (count >= (PTR_W+1)'(2));

    // head two entries
    assign issue_o.inst0 = inst_mem[rd_ptr];
    assign issue_o.pc0   = pc_mem[rd_ptr];
    assign issue_o.inst1 = inst_mem[rd_ptr_nx];
    assign issue_o.pc1   = pc_mem[rd_ptr_nx];

endmodule

/* verilog/issue_exec.sv */
module issue_exec import cpu_pkg::*; (
    input  logic                clk,
    input  logic                rst_i,

    issue_if.consumer           issue_i,

    output logic [1:0]          retire_valid_o,
    output addr_t [1:0]         retire_pc_o,
    output logic [1:0]          retire_wen_o,
    output reg_idx_t [1:0]      retire_wnum_o,
    output word_t [1:0]         retire_wdata_o
);

    reg_idx_t   m_rs, m_rt, m_wnum;
    reg_idx_t   s_rs, s_rt, s_wnum;
    word_t      m_imm, s_imm;
    logic [4:0] m_sa, s_sa;
    alu_op_e    m_op, s_op;
    logic       m_use_imm, s_use_imm;
    logic       m_wen, s_wen;
    logic       m_we, s_we;
    logic       s_dep;
    reg_idx_t   ra [4];
    word_t      rdat [4];
    word_t      m_res, s_res;

    function automatic word_t alu(alu_op_e op, word_t a, word_t b, logic [4:0] sa);
        word_t y;
        case (op)
            ALU_ADDU: y = a + b;
            ALU_SUBU: y = a - b;
            ALU_AND:  y = a & b;
            ALU_OR:   y = a | b;
            ALU_XOR:  y = a ^ b;
            ALU_SLT:  y = {31'b0, $signed(a) < $signed(b)};
            ALU_SLL:  y = b << sa;
            ALU_LUI:  y = b;
            default:  y = '0;
        endcase
        return y;
    endfunction

    inst_decoder u_dec_master (
        .inst_i    (issue_i.inst0),
        .rs_o      (m_rs),
        .rt_o      (m_rt),
        .wnum_o    (m_wnum),
        .imm_o     (m_imm),
        .shamt_o   (m_sa),
        .alu_op_o  (m_op),
        .use_imm_o (m_use_imm),
        .wen_o     (m_wen)
    );

    inst_decoder u_dec_slave (
        .inst_i    (issue_i.inst1),
        .rs_o      (s_rs),
        .rt_o      (s_rt),
        .wnum_o    (s_wnum),
        .imm_o     (s_imm),
        .shamt_o   (s_sa),
        .alu_op_o  (s_op),
        .use_imm_o (s_use_imm),
        .wen_o     (s_wen)
    );

    assign ra = '{m_rs, m_rt, s_rs, s_rt};

    regfile u_regfile (
        .clk   (clk),
        .rst_i (rst_i),
        .ra_i  (ra),
        .rd_o  (rdat),
        .we0_i (m_we),
        .wa0_i (m_wnum),
        .wd0_i (m_res),
        .we1_i (s_we),
        .wa1_i (s_wnum),
        .wd1_i (s_res)
    );

    // slave waits if it reads what the master writes
    assign s_dep = m_wen && ((s_rs == m_wnum) || (s_rt == m_wnum));

    assign issue_i.pop0 = issue_i.valid0;
    assign issue_i.pop1 = issue_i.valid0 && issue_i.valid1 && !s_dep;

    assign m_res = alu(m_op, rdat[0], m_use_imm ? m_imm : rdat[1], m_sa);
    assign s_res = alu(s_op, rdat[2], s_use_imm ? s_imm : rdat[3], s_sa);

    assign m_we = issue_i.pop0 && m_wen;
    assign s_we = issue_i.pop1 && s_wen;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            retire_valid_o <= '0;
            retire_wen_o   <= '0;
        end else begin
            retire_valid_o <= {issue_i.pop1, issue_i.pop0};
            retire_wen_o   <= {s_we, m_we};
        end
    end

    always_ff @(posedge clk) begin
        retire_pc_o    <= {issue_i.pc1, issue_i.pc0};
        retire_wnum_o  <= {s_wnum, m_wnum};
        retire_wdata_o <= {s_res, m_res};
    end

endmodule

/* verilog/issue_if.sv */
interface issue_if import cpu_pkg::*; ();

    logic  valid0;
    logic  valid1;
    inst_t inst0;
    inst_t inst1;
    addr_t pc0;
    addr_t pc1;
    // pop1 only together with pop0
    logic  pop0;
    logic  pop1;

    modport producer (
        output valid0,
        output valid1,
        output inst0,
        output inst1,
        output pc0,
        output pc1,
        input  pop0,
        input  pop1
    );

    modport consumer (
        input  valid0,
        input  valid1,
        input  inst0,
        input  inst1,
        input  pc0,
        input  pc1,
        output pop0,
        output pop1
    );

endinterface

/* verilog/regfile.sv */
module regfile import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rst_i,

    input  reg_idx_t  ra_i [4],
    output word_t     rd_o [4],

    input  logic      we0_i,
    input  reg_idx_t  wa0_i,
    input  word_t     wd0_i,
    input  logic      we1_i,
    input  reg_idx_t  wa1_i,
    input  word_t     wd1_i
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (we0_i) begin
                regs[wa0_i] <= wd0_i;
            end
            // slave is younger, so port 1 lands last
            if (we1_i) begin
                regs[wa1_i] <= wd1_i;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            rd_o[i] = (ra_i[i] == '0) ? '0 : regs[ra_i[i]];
        end
    end

endmodule
